/* verilog/checkersPkg.sv */
`default_nettype none

package checkersPkg;

	// board geometry
	localparam int boardBits  = 256;
	localparam int rowBits    = 32; // one row word, also the AXI data width
	localparam int numRows    = 8;
	localparam int squareBits = 4;
	localparam int coordBits  = 11; // raster counters, wide enough for 800 columns

	// board layout
	// row r sits in bits 32r+31:32r
	// column c of a row sits in bits 4c+3:4c of that row word
	localparam logic [squareBits-1:0] pieceEmpty     = 4'd0;
	localparam logic [squareBits-1:0] pieceRedMan    = 4'd1;
	localparam logic [squareBits-1:0] pieceBlackMan  = 4'd2;
	localparam logic [squareBits-1:0] pieceRedKing   = 4'd3;
	localparam logic [squareBits-1:0] pieceBlackKing = 4'd4; // 5..15 paint as empty

	// register map, byte offsets
	localparam int addrBits = 7;
	localparam logic [addrBits-1:0] sendRowBase  = 7'h00; // 8 words, r/w
	localparam logic [addrBits-1:0] recvRowBase  = 7'h20; // 8 words, read only
	localparam logic [addrBits-1:0] ctrlOffset   = 7'h40; // bit0 start, reads 0
	localparam logic [addrBits-1:0] statusOffset = 7'h44; // busy, newData (w1c), peerReady

	// AXI responses
	localparam logic [1:0] respOkay   = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	// 24-bit RGB, red in the top byte
	localparam logic [23:0] lightSquareRgb = 24'hE8D0A8;
	localparam logic [23:0] darkSquareRgb  = 24'h6B3E1E;
	localparam logic [23:0] redManRgb      = 24'hD01010;
	localparam logic [23:0] blackManRgb    = 24'h202020;
	localparam logic [23:0] redKingRgb     = 24'hFF7070;
	localparam logic [23:0] blackKingRgb   = 24'h606080;

endpackage

`default_nettype wire

/* verilog/boardRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module boardRegs (
	input  logic SW,
	input  logic rstN,
	// AXI4-Lite write side
	input  logic [checkersPkg::addrBits-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [checkersPkg::rowBits-1:0] wData,
	input  logic [checkersPkg::rowBits/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	// AXI4-Lite read side
	input  logic [checkersPkg::addrBits-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [checkersPkg::rowBits-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	// serial link side
	output logic [checkersPkg::boardBits-1:0] sendBoard,
	output logic startPulse,
	input  logic [checkersPkg::boardBits-1:0] recvBoard,
	input  logic busy,
	input  logic frameDone,
	input  logic peerReady,
	input  logic rxIdle,
	output logic readyForReceive
);
	import checkersPkg::*;

	localparam int rowIdxBits = $clog2(numRows);
	localparam int regionLsb = rowIdxBits + 2; // row words fill a 32-byte region

	logic [rowBits-1:0] sendRows [numRows];
	logic newData; // frame landed, not yet acknowledged
	logic wrEn, rdEn;
	logic wrSend, wrCtrl, wrStatus;
	logic rdSend, rdRecv, rdCtrl, rdStatus;
	logic [rowIdxBits-1:0] wrRow, rdRow;
	logic [rowBits-1:0] statusWord;
	logic [rowBits-1:0] rdDataNext;
	logic [1:0] rdRespNext;

	// both channels must be present, one write in flight
	assign wrEn = awValid & wValid & ~bValid;
	assign awReady = wrEn;
	assign wReady = wrEn;
	assign arReady = ~rValid; // single outstanding read
	assign rdEn = arValid & arReady;

	// write decode
	assign wrRow = awAddr[regionLsb-1:2];
	assign wrSend = awAddr[addrBits-1:regionLsb] == sendRowBase[addrBits-1:regionLsb];
	assign wrCtrl = awAddr[addrBits-1:2] == ctrlOffset[addrBits-1:2];
	assign wrStatus = awAddr[addrBits-1:2] == statusOffset[addrBits-1:2];

	// read decode
	assign rdRow = arAddr[regionLsb-1:2];
	assign rdSend = arAddr[addrBits-1:regionLsb] == sendRowBase[addrBits-1:regionLsb];
	assign rdRecv = arAddr[addrBits-1:regionLsb] == recvRowBase[addrBits-1:regionLsb];
	assign rdCtrl = arAddr[addrBits-1:2] == ctrlOffset[addrBits-1:2];
	assign rdStatus = arAddr[addrBits-1:2] == statusOffset[addrBits-1:2];

	assign statusWord = {{(rowBits-3){1'b0}}, peerReady, newData, busy};

	// hold the line low while a frame is in, or still unread
	// frameDone covers the cycle before newData shows up
	assign readyForReceive = rxIdle & ~newData & ~frameDone;

	always_comb begin
		for (int r = 0; r < numRows; r++) begin
			sendBoard[r*rowBits +: rowBits] = sendRows[r];
		end
	end

	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			bValid <= 1'b0;
			bResp <= respOkay;
			startPulse <= 1'b0;
			newData <= 1'b0;
			for (int r = 0; r < numRows; r++) begin
				sendRows[r] <= '0;
			end
		end else begin
			startPulse <= 1'b0; // one cycle only
			if (bValid && bReady)
				bValid <= 1'b0;
			if (wrEn) begin
				bValid <= 1'b1;
				bResp <= respOkay;
				if (wrSend) begin
					for (int b = 0; b < rowBits/8; b++) begin
						if (wStrb[b])
							sendRows[wrRow][8*b +: 8] <= wData[8*b +: 8];
					end
				end else if (wrCtrl) begin
					startPulse <= wData[0] & wStrb[0];
				end else if (wrStatus) begin
					if (wData[1] && wStrb[0])
						newData <= 1'b0; // w1c
				end else begin
					bResp <= respSlvErr; // recv rows and holes
				end
			end
			if (frameDone)
				newData <= 1'b1; // a fresh frame beats a clear
		end
	end

	// read mux
	always_comb begin
		rdDataNext = '0;
		rdRespNext = respOkay;
		if (rdSend)
			rdDataNext = sendRows[rdRow];
		else if (rdRecv)
			rdDataNext = recvBoard[rdRow*rowBits +: rowBits];
		else if (rdStatus)
			rdDataNext = statusWord;
		else if (!rdCtrl)
			rdRespNext = respSlvErr; // ctrl reads as zero
	end

	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN)
			rValid <= 1'b0;
		else if (rdEn)
			rValid <= 1'b1;
		else if (rReady)
			rValid <= 1'b0;
	end

	always_ff @(posedge SW) begin
		if (rdEn) begin
			rData <= rdDataNext;
			rResp <= rdRespNext;
		end
	end

	bHeld: assert property (@(posedge SW) disable iff (!rstN)
		bValid && !bReady |=> bValid && $stable(bResp))
		else $error("bValid dropped before bReady");

	rHeld: assert property (@(posedge SW) disable iff (!rstN)
		rValid && !rReady |=> rValid && $stable(rData) && $stable(rResp))
		else $error("read data moved while rValid waited");

endmodule

`default_nettype wire

/* verilog/serialLink.sv */
`timescale 1ns/1ps
`default_nettype none

module serialLink #(
	parameter int halfBitCycles = 50
) (
	input  logic SW,
	input  logic rstN,
	input  logic [checkersPkg::boardBits-1:0] sendBoard,
	input  logic startPulse,
	input  logic readyForSend, // peer's ready line
	input  logic clkIn,
	input  logic dataIn,
	output logic clkOut,
	output logic dataOut,
	output logic [checkersPkg::boardBits-1:0] recvBoard,
	output logic busy,
	output logic frameDone,
	output logic peerReady,
	output logic rxIdle
);
	import checkersPkg::*;

	localparam int bitCntBits = $clog2(boardBits);
	localparam int halfCntBits = $clog2(halfBitCycles + 1);

	typedef enum logic [1:0] {
		txIdle,
		txWaitPeer, // board latched, peer not ready yet
		txShift
	} txState_t;

	txState_t txState;
	logic [boardBits-1:0] txShiftReg;
	logic [halfCntBits-1:0] halfCnt;
	logic [bitCntBits-1:0] txBitCnt;
	logic halfDone;

	logic [1:0] clkSync, dataSync, readySync;
	logic clkPrev;
	logic clkRise;
	logic [boardBits-1:0] rxShiftReg;
	logic [bitCntBits-1:0] rxBitCnt;

	assign busy = txState != txIdle;
	assign halfDone = halfCnt == halfBitCycles - 1;

	// transmitter
	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			txState <= txIdle;
			clkOut <= 1'b0;
			dataOut <= 1'b0;
			halfCnt <= '0;
			txBitCnt <= '0;
		end else begin
			case (txState)
				txIdle: if (startPulse) txState <= txWaitPeer; // start while busy falls here only in idle
				txWaitPeer: begin
					if (peerReady) begin // only checked between frames
						txState <= txShift;
						dataOut <= txShiftReg[boardBits-1]; // row 7 msb first
						clkOut <= 1'b0;
						halfCnt <= '0;
						txBitCnt <= '0;
					end
				end
				txShift: begin
					if (halfDone) begin
						halfCnt <= '0;
						if (!clkOut) begin
							clkOut <= 1'b1; // receiver samples here
						end else begin
							clkOut <= 1'b0; // data moves on the fall
							if (txBitCnt == bitCntBits'(boardBits - 1)) begin
								txState <= txIdle;
								dataOut <= 1'b0;
							end else begin
								txBitCnt <= txBitCnt + 1'b1;
								dataOut <= txShiftReg[boardBits-2];
							end
						end
					end else begin
						halfCnt <= halfCnt + 1'b1;
					end
				end
				default: txState <= txIdle;
			endcase
		end
	end

	// shift register, no reset needed
	always_ff @(posedge SW) begin
		if (txState == txIdle && startPulse)
			txShiftReg <= sendBoard;
		else if (txState == txShift && halfDone && clkOut)
			txShiftReg <= txShiftReg << 1;
	end

	// receiver, all three lines come from the other board
	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			clkSync <= '0;
			dataSync <= '0;
			readySync <= '0;
			clkPrev <= 1'b0;
		end else begin
			clkSync <= {clkSync[0], clkIn};
			dataSync <= {dataSync[0], dataIn}; // same depth keeps data aligned to clk
			readySync <= {readySync[0], readyForSend};
			clkPrev <= clkSync[1];
		end
	end

	assign clkRise = clkSync[1] & ~clkPrev;
	assign peerReady = readySync[1];
	assign rxIdle = rxBitCnt == '0;

	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			rxBitCnt <= '0;
			recvBoard <= '0;
			frameDone <= 1'b0;
		end else begin
			frameDone <= 1'b0;
			if (clkRise) begin
				if (rxBitCnt == bitCntBits'(boardBits - 1)) begin
					rxBitCnt <= '0;
					recvBoard <= {rxShiftReg[boardBits-2:0], dataSync[1]};
					frameDone <= 1'b1;
				end else begin
					rxBitCnt <= rxBitCnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge SW) begin
		if (clkRise)
			rxShiftReg <= {rxShiftReg[boardBits-2:0], dataSync[1]};
	end

	// a start while busy must leave the latched board alone
	noRestart: assert property (@(posedge SW) disable iff (!rstN)
		startPulse && busy && !(txState == txShift && halfDone && clkOut)
		|=> $stable(txShiftReg))
		else $error("start acted on while busy");

	// no clock edges or data while nothing is going out
	idleQuiet: assert property (@(posedge SW) disable iff (!rstN)
		!busy |-> !clkOut && !dataOut)
		else $error("clkOut or dataOut high while the link is idle");

endmodule

`default_nettype wire

/* verilog/rasterTiming.sv */
`timescale 1ns/1ps
`default_nettype none

module rasterTiming #(
	parameter int hActive = 640,
	parameter int hFront  = 16,
	parameter int hSync   = 96,
	parameter int hBack   = 48,
	parameter int vActive = 480,
	parameter int vFront  = 10,
	parameter int vSync   = 2,
	parameter int vBack   = 33
) (
	input  logic SW,
	input  logic rstN,
	output logic [checkersPkg::coordBits-1:0] pixelX,
	output logic [checkersPkg::coordBits-1:0] pixelY,
	output logic pixelActive,
	output logic hSyncN,
	output logic vSyncN,
	output logic blankN
);
	import checkersPkg::*;

	localparam int hTotal = hActive + hFront + hSync + hBack;
	localparam int vTotal = vActive + vFront + vSync + vBack;

	logic [coordBits-1:0] hCnt, vCnt;
	logic hSyncRaw, vSyncRaw;

	// free running counters
	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			hCnt <= '0;
			vCnt <= '0;
		end else if (hCnt == coordBits'(hTotal - 1)) begin
			hCnt <= '0;
			if (vCnt == coordBits'(vTotal - 1))
				vCnt <= '0; // next frame
			else
				vCnt <= vCnt + 1'b1;
		end else begin
			hCnt <= hCnt + 1'b1;
		end
	end

	// coordinates go out a cycle ahead of the syncs
	assign pixelX = hCnt;
	assign pixelY = vCnt;
	assign pixelActive = (hCnt < hActive) && (vCnt < vActive);

	assign hSyncRaw = !((hCnt >= hActive + hFront) && (hCnt < hActive + hFront + hSync));
	assign vSyncRaw = !((vCnt >= vActive + vFront) && (vCnt < vActive + vFront + vSync));

	// one stage to line up with the painter's color register
	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			hSyncN <= 1'b1;
			vSyncN <= 1'b1;
			blankN <= 1'b0;
		end else begin
			hSyncN <= hSyncRaw;
			vSyncN <= vSyncRaw;
			blankN <= pixelActive;
		end
	end

endmodule

`default_nettype wire

/* verilog/boardPainter.sv */
`timescale 1ns/1ps
`default_nettype none

module boardPainter #(
	parameter int squarePixels = 60
) (
	input  logic SW,
	input  logic rstN,
	input  logic [checkersPkg::coordBits-1:0] pixelX,
	input  logic [checkersPkg::coordBits-1:0] pixelY,
	input  logic pixelActive,
	input  logic [checkersPkg::boardBits-1:0] recvBoard,
	output logic [7:0] vgaR,
	output logic [7:0] vgaG,
	output logic [7:0] vgaB
);
	import checkersPkg::*;

	localparam int sideBits = $clog2(numRows);

	logic [coordBits-1:0] colIdx, colSub, rowIdx, rowSub; // state of the last pixel
	logic [coordBits-1:0] colNow, colSubNow, rowNow, rowSubNow;
	logic [2*sideBits-1:0] sqIdx;
	logic [squareBits-1:0] code;
	logic onBoard, lightSq;
	logic [23:0] colorNow;

	// step the square counters instead of dividing
	always_comb begin
		colNow = colIdx;
		colSubNow = colSub + 1'b1;
		rowNow = rowIdx;
		rowSubNow = rowSub;
		if (pixelX == '0) begin // new line
			colNow = '0;
			colSubNow = '0;
			if (pixelY == '0) begin
				rowNow = '0;
				rowSubNow = '0;
			end else if (rowSub == coordBits'(squarePixels - 1)) begin
				rowNow = rowIdx + 1'b1;
				rowSubNow = '0;
			end else begin
				rowSubNow = rowSub + 1'b1;
			end
		end else if (colSub == coordBits'(squarePixels - 1)) begin
			colNow = colIdx + 1'b1;
			colSubNow = '0;
		end
	end

	always_ff @(posedge SW or negedge rstN) begin
		if (!rstN) begin
			colIdx <= '0;
			colSub <= '0;
			rowIdx <= '0;
			rowSub <= '0;
		end else begin
			colIdx <= colNow;
			colSub <= colSubNow;
			rowIdx <= rowNow;
			rowSub <= rowSubNow;
		end
	end

	assign onBoard = pixelActive && (colNow < numRows) && (rowNow < numRows);
	assign sqIdx = {rowNow[sideBits-1:0], colNow[sideBits-1:0]}; // row*8 + col
	assign code = recvBoard[sqIdx*squareBits +: squareBits];
	assign lightSq = ~(rowNow[0] ^ colNow[0]); // even sum is light

	always_comb begin
		case (code)
			pieceRedMan:    colorNow = redManRgb;
			pieceBlackMan:  colorNow = blackManRgb;
			pieceRedKing:   colorNow = redKingRgb;
			pieceBlackKing: colorNow = blackKingRgb;
			default:        colorNow = lightSq ? lightSquareRgb : darkSquareRgb; // empty or junk code
		endcase
	end

	always_ff @(posedge SW) begin
		{vgaR, vgaG, vgaB} <= onBoard ? colorNow : 24'h000000; // black off board
	end

endmodule

`default_nettype wire

/* verilog/checkersLinkTop.sv */
`timescale 1ns/1ps
`default_nettype none

module checkersLinkTop #(
	parameter int halfBitCycles = 50,
	parameter int squarePixels  = 60,
	parameter int hActive = 640,
	parameter int hFront  = 16,
	parameter int hSync   = 96,
	parameter int hBack   = 48,
	parameter int vActive = 480,
	parameter int vFront  = 10,
	parameter int vSync   = 2,
	parameter int vBack   = 33
) (
	input  logic SW,
	input  logic rstN,
	input  logic [checkersPkg::addrBits-1:0] awAddr,
	input  logic awValid,
	output logic awReady,
	input  logic [checkersPkg::rowBits-1:0] wData,
	input  logic [checkersPkg::rowBits/8-1:0] wStrb,
	input  logic wValid,
	output logic wReady,
	output logic [1:0] bResp,
	output logic bValid,
	input  logic bReady,
	input  logic [checkersPkg::addrBits-1:0] arAddr,
	input  logic arValid,
	output logic arReady,
	output logic [checkersPkg::rowBits-1:0] rData,
	output logic [1:0] rResp,
	output logic rValid,
	input  logic rReady,
	input  logic clkIn,        // from peer sender
	input  logic dataIn,
	input  logic readyForSend, // peer receiver ready
	output logic clkOut,
	output logic dataOut,
	output logic readyForReceive,
	output logic [7:0] vgaR,
	output logic [7:0] vgaG,
	output logic [7:0] vgaB,
	output logic hSyncN,
	output logic vSyncN,
	output logic blankN
);
	import checkersPkg::*;

	logic [boardBits-1:0] sendBoard, recvBoard;
	logic startPulse, busy, frameDone, peerReady, rxIdle;
	logic [coordBits-1:0] pixelX, pixelY;
	logic pixelActive;

	boardRegs boardRegs_inst (
		.SW(SW), .rstN(rstN),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
		.sendBoard(sendBoard), .startPulse(startPulse), .recvBoard(recvBoard),
		.busy(busy), .frameDone(frameDone), .peerReady(peerReady),
		.rxIdle(rxIdle), .readyForReceive(readyForReceive)
	);

	serialLink #(.halfBitCycles(halfBitCycles)) serialLink_inst (
		.SW(SW), .rstN(rstN),
		.sendBoard(sendBoard), .startPulse(startPulse), .readyForSend(readyForSend),
		.clkIn(clkIn), .dataIn(dataIn), .clkOut(clkOut), .dataOut(dataOut),
		.recvBoard(recvBoard), .busy(busy), .frameDone(frameDone),
		.peerReady(peerReady), .rxIdle(rxIdle)
	);

	rasterTiming #(
		.hActive(hActive), .hFront(hFront), .hSync(hSync), .hBack(hBack),
		.vActive(vActive), .vFront(vFront), .vSync(vSync), .vBack(vBack)
	) rasterTiming_inst (
		.SW(SW), .rstN(rstN),
		.pixelX(pixelX), .pixelY(pixelY), .pixelActive(pixelActive),
		.hSyncN(hSyncN), .vSyncN(vSyncN), .blankN(blankN)
	);

	// paints the board that came in, not the one we send
	boardPainter #(.squarePixels(squarePixels)) boardPainter_inst (
		.SW(SW), .rstN(rstN),
		.pixelX(pixelX), .pixelY(pixelY), .pixelActive(pixelActive),
		.recvBoard(recvBoard),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB)
	);

endmodule

`default_nettype wire

/* verif/checkersLinkTb.sv */
`timescale 1ns/1ps
`default_nettype none

module checkersLinkTb;
	import checkersPkg::*;

	localparam int halfBits = 2;
	localparam int sqPix = 4;
	localparam int hAct = 32;
	localparam int hFrontPix = 2;
	localparam int hSyncPix = 2;
	localparam int vAct = 32;
	localparam int frameCycles = boardBits * 2 * halfBits + 16; // one serial frame, some slack
	localparam int handshakeLimit = 20;
	localparam int pollLimit = 1000; // status reads
	localparam int rasterLimit = 4000; // about three video frames

	logic SW, rstN;
	logic [addrBits-1:0] awAddr, arAddr;
	logic awValid, awReady, wValid, wReady, bValid, bReady;
	logic [rowBits-1:0] wData, rData;
	logic [rowBits/8-1:0] wStrb;
	logic [1:0] bResp, rResp;
	logic arValid, arReady, rValid, rReady;
	logic clkOut, dataOut, readyForReceive; // looped back into the DUT
	logic [7:0] vgaR, vgaG, vgaB;
	logic hSyncN, vSyncN, blankN;

	int errorCount, timeoutCount;
	logic [31:0] lcgState;
	string curTest;
	logic [rowBits-1:0] sendModel [numRows]; // expected send rows
	logic [rowBits-1:0] recvModel [numRows]; // board that should have landed

	checkersLinkTop #(
		.halfBitCycles(halfBits), .squarePixels(sqPix),
		.hActive(hAct), .hFront(hFrontPix), .hSync(hSyncPix), .hBack(2),
		.vActive(vAct), .vFront(1), .vSync(1), .vBack(1)
	) checkersLinkTop_inst (
		.SW(SW), .rstN(rstN),
		.awAddr(awAddr), .awValid(awValid), .awReady(awReady),
		.wData(wData), .wStrb(wStrb), .wValid(wValid), .wReady(wReady),
		.bResp(bResp), .bValid(bValid), .bReady(bReady),
		.arAddr(arAddr), .arValid(arValid), .arReady(arReady),
		.rData(rData), .rResp(rResp), .rValid(rValid), .rReady(rReady),
		.clkIn(clkOut), .dataIn(dataOut), .readyForSend(readyForReceive), // loopback
		.clkOut(clkOut), .dataOut(dataOut), .readyForReceive(readyForReceive),
		.vgaR(vgaR), .vgaG(vgaG), .vgaB(vgaB),
		.hSyncN(hSyncN), .vSyncN(vSyncN), .blankN(blankN)
	);

	initial begin
		SW = 1'b0;
		forever #20 SW = ~SW;
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// color from the piece rule, square parity otherwise
	function automatic logic [23:0] squareColor(input logic [3:0] code, input int row, input int col);
		case (code)
			4'd1: return redManRgb;
			4'd2: return blackManRgb;
			4'd3: return redKingRgb;
			4'd4: return blackKingRgb;
			default: return ((row + col) % 2 == 0) ? lightSquareRgb : darkSquareRgb;
		endcase
	endfunction

	task automatic reportMismatch(input string testName, input logic [31:0] expVal,
			input logic [31:0] actVal);
		errorCount++;
		$display("FAILED %s: expected 0x%h, actual 0x%h", testName, expVal, actVal);
	endtask

	task automatic reportTimeout(input string what);
		timeoutCount++;
		$display("TIMEOUT in %s: gave up waiting for %s", curTest, what);
	endtask

	task automatic axiWrite(input logic [addrBits-1:0] addr, input logic [31:0] data,
			input logic [3:0] strb, output logic [1:0] resp);
		int n;
		@(posedge SW);
		awAddr <= addr;
		awValid <= 1'b1;
		wData <= data;
		wStrb <= strb;
		wValid <= 1'b1;
		n = 0;
		do begin
			@(negedge SW);
			n++;
		end while (!(awReady && wReady) && n < handshakeLimit);
		if (!(awReady && wReady))
			reportTimeout("awReady and wReady");
		@(posedge SW); // address and data taken here
		awValid <= 1'b0;
		wValid <= 1'b0;
		bReady <= 1'b1;
		n = 0;
		do begin
			@(negedge SW);
			n++;
		end while (!bValid && n < handshakeLimit);
		if (!bValid)
			reportTimeout("bValid");
		resp = bResp;
		@(posedge SW); // response retires
		bReady <= 1'b0;
	endtask

	task automatic axiRead(input logic [addrBits-1:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		int n;
		@(posedge SW);
		arAddr <= addr;
		arValid <= 1'b1;
		n = 0;
		do begin
			@(negedge SW);
			n++;
		end while (!arReady && n < handshakeLimit);
		if (!arReady)
			reportTimeout("arReady");
		@(posedge SW);
		arValid <= 1'b0;
		rReady <= 1'b1;
		n = 0;
		do begin
			@(negedge SW);
			n++;
		end while (!rValid && n < handshakeLimit);
		if (!rValid)
			reportTimeout("rValid");
		data = rData;
		resp = rResp;
		@(posedge SW);
		rReady <= 1'b0;
	endtask

	task automatic waitNewData();
		logic [31:0] st;
		logic [1:0] rsp;
		int n;
		n = 0;
		do begin
			axiRead(statusOffset, st, rsp);
			n++;
		end while (!st[1] && n < pollLimit);
		if (!st[1])
			reportTimeout("status newData");
	endtask

	task automatic writeSendRows();
		logic [1:0] rsp;
		for (int r = 0; r < numRows; r++) begin
			axiWrite(addrBits'(sendRowBase + 4 * r), sendModel[r], 4'hF, rsp);
			if (rsp !== respOkay)
				reportMismatch({curTest, " send write resp"}, respOkay, rsp);
		end
	endtask

	task automatic checkSendRows();
		logic [31:0] rd;
		logic [1:0] rsp;
		for (int r = 0; r < numRows; r++) begin
			axiRead(addrBits'(sendRowBase + 4 * r), rd, rsp);
			if (rd !== sendModel[r])
				reportMismatch($sformatf("%s send row %0d", curTest, r), sendModel[r], rd);
		end
	endtask

	task automatic checkRecvRows();
		logic [31:0] rd;
		logic [1:0] rsp;
		for (int r = 0; r < numRows; r++) begin
			axiRead(addrBits'(recvRowBase + 4 * r), rd, rsp);
			if (rd !== recvModel[r])
				reportMismatch($sformatf("%s recv row %0d", curTest, r), recvModel[r], rd);
		end
	endtask

	task automatic startTransfer();
		logic [1:0] rsp;
		axiWrite(ctrlOffset, 32'h1, 4'hF, rsp);
		if (rsp !== respOkay)
			reportMismatch({curTest, " ctrl resp"}, respOkay, rsp);
	endtask

	task automatic clearNewData();
		logic [1:0] rsp;
		axiWrite(statusOffset, 32'h2, 4'hF, rsp); // w1c on bit 1
		if (rsp !== respOkay)
			reportMismatch({curTest, " status resp"}, respOkay, rsp);
	endtask

	task automatic testRegAccess();
		logic [31:0] rd;
		logic [1:0] rsp;
		curTest = "regAccess";
		axiRead(statusOffset, rd, rsp);
		if (rd[1:0] !== 2'b00) // busy and newData
			reportMismatch({curTest, " status"}, 32'h0, rd[1:0]);
		checkRecvRows(); // still all zero
		for (int r = 0; r < numRows; r++)
			sendModel[r] = lcgNext();
		writeSendRows();
		checkSendRows();
		axiWrite(addrBits'(sendRowBase + 8), 32'hA5C3_5A3C, 4'b0101, rsp); // bytes 0 and 2
		sendModel[2][7:0] = 8'h3C;
		sendModel[2][23:16] = 8'hC3;
		axiWrite(addrBits'(sendRowBase + 20), 32'h7E00_0000, 4'b1000, rsp); // top byte only
		sendModel[5][31:24] = 8'h7E;
		checkSendRows();
	endtask

	task automatic testBadAccess();
		logic [31:0] rd;
		logic [1:0] rsp;
		curTest = "badAccess";
		axiWrite(addrBits'(recvRowBase + 4), 32'hFFFF_FFFF, 4'hF, rsp);
		if (rsp !== respSlvErr)
			reportMismatch({curTest, " recv write resp"}, respSlvErr, rsp);
		axiWrite(7'h50, 32'h0000_0003, 4'hF, rsp); // hole in the map
		if (rsp !== respSlvErr)
			reportMismatch({curTest, " hole write resp"}, respSlvErr, rsp);
		axiRead(7'h50, rd, rsp);
		if (rd !== 32'h0)
			reportMismatch({curTest, " hole read data"}, 32'h0, rd);
		if (rsp !== respSlvErr)
			reportMismatch({curTest, " hole read resp"}, respSlvErr, rsp);
		checkRecvRows();
		checkSendRows();
	endtask

	task automatic testLoopback();
		logic [31:0] rd;
		logic [1:0] rsp;
		curTest = "loopback";
		startTransfer();
		waitNewData();
		for (int r = 0; r < numRows; r++)
			recvModel[r] = sendModel[r];
		checkRecvRows();
		clearNewData();
		axiRead(statusOffset, rd, rsp);
		if (rd[1] !== 1'b0)
			reportMismatch({curTest, " newData after clear"}, 32'h0, rd[1]);
	endtask

	task automatic testHeldReady();
		logic [31:0] rd;
		logic [1:0] rsp;
		curTest = "heldReady";
		startTransfer(); // same board again, leaves newData set
		waitNewData();
		for (int r = 0; r < numRows; r++)
			sendModel[r] = lcgNext();
		writeSendRows();
		startTransfer();
		repeat (3 * frameCycles) @(posedge SW); // sender should sit waiting
		checkRecvRows();
		axiRead(statusOffset, rd, rsp);
		if (rd[2:0] !== 3'b011) // peer not ready, newData, busy
			reportMismatch({curTest, " status while held"}, 32'h3, rd[2:0]);
		clearNewData();
		waitNewData();
		for (int r = 0; r < numRows; r++)
			recvModel[r] = sendModel[r];
		checkRecvRows();
		clearNewData();
	endtask

	task automatic testPainting();
		logic prevSync, fell, expSync;
		logic [23:0] expRgb;
		int n, k, x, y, row, col, gap;
		curTest = "painting";
		for (int r = 0; r < numRows; r++)
			sendModel[r] = '0;
		sendModel[0][3:0] = pieceRedMan;
		sendModel[0][7:4] = pieceBlackMan;
		sendModel[1][11:8] = pieceRedKing;
		sendModel[3][23:20] = pieceBlackKing;
		sendModel[4][19:16] = 4'hB; // junk code on a light square
		sendModel[5][11:8] = 4'hF; // junk on dark
		writeSendRows();
		startTransfer();
		waitNewData();
		for (int r = 0; r < numRows; r++)
			recvModel[r] = sendModel[r];
		// find the start of a frame
		n = 0;
		prevSync = 1'b0;
		fell = 1'b0;
		do begin
			@(negedge SW);
			n++;
			fell = prevSync && !vSyncN;
			prevSync = vSyncN;
		end while (!fell && n < rasterLimit);
		if (!fell)
			reportTimeout("falling vSyncN");
		k = 0;
		n = 0;
		gap = 0;
		while (k < hAct * vAct && n < rasterLimit) begin
			@(negedge SW);
			n++;
			if (blankN) begin
				if (hSyncN !== 1'b1)
					reportMismatch({curTest, " hSyncN in active video"}, 32'h1, hSyncN);
				gap = 0;
				x = k % hAct;
				y = k / hAct;
				if (x % sqPix == sqPix / 2 && y % sqPix == sqPix / 2) begin // square center
					row = y / sqPix;
					col = x / sqPix;
					expRgb = squareColor(recvModel[row][4*col +: 4], row, col);
					if ({vgaR, vgaG, vgaB} !== expRgb)
						reportMismatch($sformatf("%s row %0d col %0d", curTest, row, col),
							expRgb, {vgaR, vgaG, vgaB});
				end
				k++;
			end else if (k > 0) begin // blank gap between two active lines
				expSync = !(gap >= hFrontPix && gap < hFrontPix + hSyncPix);
				if (hSyncN !== expSync)
					reportMismatch($sformatf("%s hSyncN blank cycle %0d", curTest, gap),
						expSync, hSyncN);
				gap++;
			end
		end
		if (k < hAct * vAct)
			reportTimeout("a full frame of active pixels");
	endtask

	initial begin
		rstN = 1'b0;
		awAddr = '0;
		awValid = 1'b0;
		wData = '0;
		wStrb = '0;
		wValid = 1'b0;
		bReady = 1'b0;
		arAddr = '0;
		arValid = 1'b0;
		rReady = 1'b0;
		lcgState = 32'd27;
		errorCount = 0;
		timeoutCount = 0;
		curTest = "reset";
		for (int r = 0; r < numRows; r++) begin
			sendModel[r] = '0;
			recvModel[r] = '0;
		end
		repeat (2) @(posedge SW);
		rstN <= 1'b1;
		@(posedge SW);
		testRegAccess();
		testBadAccess();
		testLoopback();
		testHeldReady();
		testPainting();
		$display("errors: %0d mismatches, %0d timeouts", errorCount, timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
verilog/checkersPkg.sv
verilog/boardRegs.sv
verilog/serialLink.sv
verilog/rasterTiming.sv
verilog/boardPainter.sv
verilog/checkersLinkTop.sv
verif/checkersLinkTb.sv
